// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tbTop
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: source/byteWordBuffer.sv
`timescale 1ns/1ns

module byteWordBuffer
    import streamPkg::*;
#(
    parameter int pDepth      = defDepth,
    parameter int pFullMargin = defFullMargin
)
(
    input  logic iClk,
    input  logic rst,
    // byte producer
    input  byteT wrData,
    input  logic wrStrobe,
    // drain control
    input  logic drainEn,
    // word output
    output wordT wordOut,
    output logic wordValid,
    // status
    output logic full,
    output logic empty,
    output logic overflow
);

    // --------------------
    // FIFO to assembler
    // --------------------
    logic rdReq;
    byteT rdData;
    logic rdValid;

    // byte storage with flags
    fifoController #(
        .pDepth      (pDepth),
        .pFullMargin (pFullMargin)
    ) ctrlInst (
        .iClk     (iClk),
        .rst      (rst),
        .wrData   (wrData),
        .wrStrobe (wrStrobe),
        .full     (full),
        .empty    (empty),
        .overflow (overflow),
        .rdReq    (rdReq),
        .rdData   (rdData),
        .rdValid  (rdValid)
    );

    // byte pairs into words
    wordAssembler asmInst (
        .iClk      (iClk),
        .rst       (rst),
        .drainEn   (drainEn),
        .rdReq     (rdReq),
        .rdData    (rdData),
        .rdValid   (rdValid),
        .wordOut   (wordOut),
        .wordValid (wordValid)
    );

endmodule

// File: source/fifoController.sv
`timescale 1ns/1ns

module fifoController
    import streamPkg::*;
#(
    parameter int pDepth      = defDepth,
    parameter int pFullMargin = defFullMargin
)
(
    input  logic iClk,
    input  logic rst,
    // producer side
    input  byteT wrData,
    input  logic wrStrobe,
    output logic full,
    output logic empty,
    output logic overflow,
    // consumer side
    input  logic rdReq,
    output byteT rdData,
    output logic rdValid
);

    // address width follows the depth
    localparam int addrW = $clog2(pDepth);

    typedef logic [addrW-1:0] addrT;

    // one slot stays unused so equal pointers mean empty
    localparam addrT capacity   = addrT'(pDepth - 1);
    localparam addrT fullMargin = addrT'(pFullMargin);

    addrT wrPtr;
    addrT rdPtr;
    addrT rdPtrDly;
    addrT fillLevel;
    addrT freeSlots;
    logic ptrEqual;
    logic atCapacity;
    logic wrAccept;
    logic rdAccept;
    byteT memData;

    // --------------------
    // fill level
    // --------------------
    // modular difference, never above capacity
    assign fillLevel  = wrPtr - rdPtr;
    assign freeSlots  = capacity - fillLevel;
    assign ptrEqual   = (wrPtr == rdPtr);
    assign atCapacity = (fillLevel == capacity);

    // writes at capacity are lost
    assign wrAccept = wrStrobe && !atCapacity;
    // reads while empty are ignored, uses the live compare not the flag
    assign rdAccept = rdReq && !ptrEqual;

    // --------------------
    // pointers
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (rst)
        begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            rdPtrDly <= '0;
        end
        else
        begin
            if (wrAccept)
            begin
                wrPtr <= wrPtr + addrT'(1);
            end
            if (rdAccept)
            begin
                rdPtr <= rdPtr + addrT'(1);
            end
            // previous read pointer, a change means a byte is on its way
            rdPtrDly <= rdPtr;
        end
    end

    // --------------------
    // status flags
    // --------------------
    // all registered one cycle behind the pointers
    always_ff @(posedge iClk)
    begin
        if (rst)
        begin
            full     <= 1'b0;
            empty    <= 1'b0;
            rdValid  <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            // early full, leaves room for slow producers
            full    <= (freeSlots <= fullMargin);
            empty   <= ptrEqual;
            rdValid <= (rdPtr != rdPtrDly);
            // sticky until reset
            if (wrStrobe && atCapacity)
            begin
                overflow <= 1'b1;
            end
        end
    end

    fifoMemory #(
        .pDepth (pDepth)
    ) memInst (
        .iClk   (iClk),
        .we     (wrAccept),
        .wrAddr (wrPtr),
        .wrData (wrData),
        .rdAddr (rdPtr),
        .rdData (memData)
    );

    // second data stage, lines up with rdValid
    always_ff @(posedge iClk)
    begin
        rdData <= memData;
    end

    // --------------------
    // checks
    // --------------------
    // a valid byte needs a pointer move two clocks before
    assertValidNeedsMove: assert property (@(posedge iClk) disable iff (rst)
        rdValid |-> $past(rdAccept, 2));

    // read pointer never passes the write pointer
    assertNoUnderrun: assert property (@(posedge iClk) disable iff (rst)
        (fillLevel == '0) |=> (fillLevel <= addrT'(1)));

    // write pointer never laps the read pointer
    assertNoOverrun: assert property (@(posedge iClk) disable iff (rst)
        (fillLevel == capacity) |=> (fillLevel >= capacity - addrT'(1)));

endmodule

// File: source/fifoMemory.sv
`timescale 1ns/1ns

module fifoMemory
    import streamPkg::*;
#(
    parameter int pDepth = defDepth
)
(
    input  logic                       iClk,
    // write port
    input  logic                       we,
    input  logic [$clog2(pDepth)-1:0]  wrAddr,
    input  byteT                       wrData,
    // read port
    input  logic [$clog2(pDepth)-1:0]  rdAddr,
    output byteT                       rdData
);

    // storage array, plain registers
    byteT mem [pDepth];

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (we)
        begin
            mem[wrAddr] <= wrData;
        end
    end

    // --------------------
    // registered read port
    // --------------------
    // data shows up one clock after the address
    always_ff @(posedge iClk)
    begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: source/streamPkg.sv
package streamPkg;

    // --------------------
    // stream data widths
    // --------------------

    // one element on the write side
    typedef logic [7:0] byteT;

    // packed pair of bytes, low byte in bits 7:0
    typedef logic [15:0] wordT;

    // --------------------
    // assembler states
    // --------------------

    // asmLow waits for the first byte of a pair
    // asmHigh holds the low byte until the second one arrives
    typedef enum logic {
        asmLow,
        asmHigh
    } asmStateT;

    // default sizing for the top level
    localparam int defDepth      = 16;
    localparam int defFullMargin = 6;

endpackage

// File: source/wordAssembler.sv
`timescale 1ns/1ns

module wordAssembler
    import streamPkg::*;
(
    input  logic iClk,
    input  logic rst,
    // drain control
    input  logic drainEn,
    // FIFO read side
    output logic rdReq,
    input  byteT rdData,
    input  logic rdValid,
    // word output
    output wordT wordOut,
    output logic wordValid
);

    asmStateT state;
    byteT     lowByte;

    // request every cycle while draining
    // the controller drops requests while empty
    assign rdReq = drainEn;

    // --------------------
    // pairing FSM
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (rst)
        begin
            state     <= asmLow;
            wordValid <= 1'b0;
        end
        else
        begin
            // strobe lasts one cycle
            wordValid <= 1'b0;
            if (rdValid)
            begin
                case (state)
                    asmLow:
                    begin
                        state <= asmHigh;
                    end
                    asmHigh:
                    begin
                        state     <= asmLow;
                        wordValid <= 1'b1;
                    end
                    default:
                    begin
                        state <= asmLow;
                    end
                endcase
            end
        end
    end

    // --------------------
    // data path
    // --------------------
    always_ff @(posedge iClk)
    begin
        if (rdValid && state == asmLow)
        begin
            lowByte <= rdData;
        end
        // second byte goes to the top half
        if (rdValid && state == asmHigh)
        begin
            wordOut <= {rdData, lowByte};
        end
    end

    // a word takes two reads, so never back to back
    assertWordSpacing: assert property (@(posedge iClk) disable iff (rst)
        wordValid |=> !wordValid);

endmodule

// File: tb.f
source/streamPkg.sv
source/fifoMemory.sv
source/fifoController.sv
source/wordAssembler.sv
source/byteWordBuffer.sv
tb/tbChecker.sv
tb/tbTop.sv

// File: tb/tbChecker.sv
`timescale 1ns/1ns

module tbChecker
    import streamPkg::*;
#(
    parameter int pDepth = defDepth
)
(
    input  logic iClk,
    input  logic rst,
    // DUT ports
    input  byteT wrData,
    input  logic wrStrobe,
    input  wordT wordOut,
    input  logic wordValid,
    input  logic full,
    input  logic empty,
    input  logic overflow,
    // end of row with expected values
    input  logic rowDone,
    input  int   rowIdx,
    input  int   expWords,
    input  logic expEmpty,
    input  logic expFull,
    input  logic expOvf,
    output int   errCount
);

    // accepted bytes not yet seen in a word
    byteT expQ [$];
    wordT expWord;
    int   wordCount;
    int   rowErrs;

    // next two queued bytes, low byte first
    task automatic compareWord();
        if (expQ.size() < 2)
        begin
            $display("error at %0t: word %h came out with no byte pair queued", $time, wordOut);
            rowErrs = rowErrs + 1;
        end
        else
        begin
            expWord = {expQ[1], expQ[0]};
            void'(expQ.pop_front());
            void'(expQ.pop_front());
            if (wordOut !== expWord)
            begin
                $display("mismatch at %0t: word %h expected %h", $time, wordOut, expWord);
                rowErrs = rowErrs + 1;
            end
        end
        wordCount = wordCount + 1;
    endtask

    // flags and word count at the end of a row
    task automatic reportRow();
        if (wordCount != expWords)
        begin
            $display("mismatch at %0t: test %0d gave %0d words, expected %0d",
                $time, rowIdx, wordCount, expWords);
            rowErrs = rowErrs + 1;
        end
        if (empty !== expEmpty || full !== expFull || overflow !== expOvf)
        begin
            $display("mismatch at %0t: test %0d flags e%b f%b o%b, expected e%b f%b o%b",
                $time, rowIdx, empty, full, overflow, expEmpty, expFull, expOvf);
            rowErrs = rowErrs + 1;
        end
        $display("test %0d: %0d words, empty %b full %b overflow %b, %0d errors",
            rowIdx, wordCount, empty, full, overflow, rowErrs);
        errCount  = errCount + rowErrs;
        rowErrs   = 0;
        wordCount = 0;
    endtask

    // --------------------
    // model
    // --------------------
    always @(posedge iClk)
    begin
        if (rst)
        begin
            expQ.delete();
            wordCount = 0;
            rowErrs   = 0;
            errCount  = 0;
        end
        else
        begin
            // one slot always free, extra writes are lost
            if (wrStrobe && expQ.size() < pDepth - 1)
            begin
                expQ.push_back(wrData);
            end
            if (wordValid)
            begin
                compareWord();
            end
            if (rowDone)
            begin
                reportRow();
            end
        end
    end

endmodule

// File: tb/tbTop.sv
`timescale 1ns/1ns

module tbTop
    import streamPkg::*;
();

    localparam int depth      = 16;
    localparam int fullMargin = 6;
    localparam int rowCount   = 8;

    // one test step, flags are the levels expected after the gap
    typedef struct packed {
        int   nBytes;
        logic drain;
        int   gap;
        int   words;
        logic expEmpty;
        logic expFull;
        logic expOvf;
    } rowT;

    // bytes, drain, gap, words, empty, full, overflow
    localparam rowT stim [rowCount] = '{
        // idle after reset
        '{0,  1'b0, 4,  0,  1'b1, 1'b0, 1'b0},
        // short burst held back
        '{6,  1'b0, 4,  0,  1'b0, 1'b0, 1'b0},
        '{0,  1'b1, 12, 3,  1'b1, 1'b0, 1'b0},
        // above depth-1-margin, full rises
        '{10, 1'b0, 4,  0,  1'b0, 1'b1, 1'b0},
        '{0,  1'b1, 16, 5,  1'b1, 1'b0, 1'b0},
        // write and drain every cycle
        '{40, 1'b1, 12, 20, 1'b1, 1'b0, 1'b0},
        // 20 in, only 15 fit
        '{20, 1'b0, 4,  0,  1'b0, 1'b1, 1'b1},
        // odd byte stays in the assembler
        '{0,  1'b1, 22, 7,  1'b1, 1'b0, 1'b1}
    };

    logic iClk;
    logic rst;
    byteT wrData;
    logic wrStrobe;
    logic drainEn;
    wordT wordOut;
    logic wordValid;
    logic full;
    logic empty;
    logic overflow;

    // row handshake to the checker
    logic rowDone;
    int   rowIdx;
    int   expWords;
    logic expEmpty;
    logic expFull;
    logic expOvf;
    int   errCount;

    int seed;
    int cycleCount;
    int cycleLimit;

    // --------------------
    // clock
    // --------------------
    initial
    begin
        iClk = 1'b0;
        forever #10 iClk = ~iClk;
    end

    // one row: bytes back to back, then idle gap, then flag check
    task automatic runRow(input int r);
        int rnd;
        @(negedge iClk);
        drainEn = stim[r].drain;
        for (int i = 0; i < stim[r].nBytes; i++)
        begin
            rnd      = $random(seed);
            wrData   = rnd[7:0];
            wrStrobe = 1'b1;
            @(negedge iClk);
        end
        wrStrobe = 1'b0;
        repeat (stim[r].gap) @(negedge iClk);
        rowIdx   = r;
        expWords = stim[r].words;
        expEmpty = stim[r].expEmpty;
        expFull  = stim[r].expFull;
        expOvf   = stim[r].expOvf;
        rowDone  = 1'b1;
        @(negedge iClk);
        rowDone  = 1'b0;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial
    begin
        seed       = 78;
        rst        = 1'b1;
        wrData     = '0;
        wrStrobe   = 1'b0;
        drainEn    = 1'b0;
        rowDone    = 1'b0;
        rowIdx     = 0;
        expWords   = 0;
        expEmpty   = 1'b0;
        expFull    = 1'b0;
        expOvf     = 1'b0;
        cycleCount = 0;
        // reset, all rows, slack
        cycleLimit = 16 + 40;
        for (int r = 0; r < rowCount; r++)
        begin
            cycleLimit = cycleLimit + stim[r].nBytes + stim[r].gap + 2;
        end
        repeat (16) @(posedge iClk);
        @(negedge iClk);
        rst = 1'b0;
        for (int r = 0; r < rowCount; r++)
        begin
            runRow(r);
        end
        repeat (2) @(negedge iClk);
        $display("summary: %0d tests run, %0d errors", rowCount, errCount);
        if (errCount == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

    // --------------------
    // timeout
    // --------------------
    always @(posedge iClk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    byteWordBuffer #(
        .pDepth      (depth),
        .pFullMargin (fullMargin)
    ) DUT (
        .iClk      (iClk),
        .rst       (rst),
        .wrData    (wrData),
        .wrStrobe  (wrStrobe),
        .drainEn   (drainEn),
        .wordOut   (wordOut),
        .wordValid (wordValid),
        .full      (full),
        .empty     (empty),
        .overflow  (overflow)
    );

    tbChecker #(
        .pDepth (depth)
    ) checkInst (
        .iClk      (iClk),
        .rst       (rst),
        .wrData    (wrData),
        .wrStrobe  (wrStrobe),
        .wordOut   (wordOut),
        .wordValid (wordValid),
        .full      (full),
        .empty     (empty),
        .overflow  (overflow),
        .rowDone   (rowDone),
        .rowIdx    (rowIdx),
        .expWords  (expWords),
        .expEmpty  (expEmpty),
        .expFull   (expFull),
        .expOvf    (expOvf),
        .errCount  (errCount)
    );

endmodule
